//--- verilog/leaf_pkg.sv
`default_nettype none

package leaf_pkg;

    // packet and field widths
    localparam int PACKET_BITS   = 49;
    localparam int PAYLOAD_BITS  = 32;
    localparam int NUM_LEAF_BITS = 5;
    localparam int NUM_PORT_BITS = 4;
    localparam int NUM_ADDR_BITS = 7;

    localparam int NUM_IN_PORTS  = 4;
    localparam int NUM_OUT_PORTS = 3;

    localparam int FIFO_DEPTH            = 8;
    localparam int CREDIT_BITS           = 4;
    localparam int CREDIT_INIT           = 8;  // downstream queue depth
    localparam int FREESPACE_UPDATE_SIZE = 4;

    // control traffic goes to port 0 and user data to ports 1..4
    localparam int CTRL_PORT = 0;

    typedef logic [PAYLOAD_BITS-1:0]  payload_t;
    typedef logic [NUM_LEAF_BITS-1:0] leaf_id_t;
    typedef logic [NUM_PORT_BITS-1:0] port_id_t;
    typedef logic [NUM_ADDR_BITS-1:0] pkt_addr_t;  // msb set for config and clear for credit return
    typedef logic [CREDIT_BITS-1:0]   credit_t;

    typedef struct packed {
        logic      valid;
        leaf_id_t  leaf;
        port_id_t  port;
        pkt_addr_t addr;
        payload_t  payload;
    } bft_packet_t;

    // route table entry as carried in the low bits of a config payload
    typedef struct packed {
        leaf_id_t leaf;
        port_id_t port;
    } route_t;

endpackage

`default_nettype wire

//--- verilog/leaf_rx_decode.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_rx_decode
    import leaf_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire bft_packet_t        din,
    output logic [NUM_IN_PORTS-1:0] wr_en,
    output payload_t                wr_data,
    output logic                    ctrl_valid,
    output pkt_addr_t               ctrl_addr,
    output payload_t                ctrl_payload
);

    payload_t payload_q;

    assign wr_data      = payload_q;  // queues and control share the payload register
    assign ctrl_payload = payload_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en      <= '0;
            ctrl_valid <= 1'b0;
        end else begin
            ctrl_valid <= din.valid && (din.port == port_id_t'(CTRL_PORT));
            // data port n writes queue n-1 and ports above 4 fall through
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                wr_en[i] <= din.valid && (int'(din.port) == i + 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        payload_q <= din.payload;
        ctrl_addr <= din.addr;
    end

endmodule

`default_nettype wire

//--- verilog/port_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module port_fifo
    import leaf_pkg::*;
#(
    parameter int DEPTH = FIFO_DEPTH  // power of two so the pointers wrap naturally
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           wr_en,
    input  wire payload_t wr_data,
    input  wire           ack,
    output logic          vld,
    output payload_t      rd_data,
    output logic          pop
);

    localparam int PTR_BITS = $clog2(DEPTH);

    payload_t            mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [PTR_BITS-1:0] rd_ptr_q;
    logic [PTR_BITS:0]   count_q;
    logic                full;
    logic                push;

    assign full    = (count_q == (PTR_BITS+1)'(DEPTH));
    assign push    = wr_en & ~full;
    assign vld     = (count_q != '0);
    assign pop     = vld & ack;  // word leaves on vld and ack
    assign rd_data = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + PTR_BITS'(push);
            rd_ptr_q <= rd_ptr_q + PTR_BITS'(pop);
            count_q  <= count_q + (PTR_BITS+1)'(push) - (PTR_BITS+1)'(pop);
        end
    end

endmodule

`default_nettype wire

//--- verilog/leaf_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_ctrl
    import leaf_pkg::*;
(
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                ap_start,
    input  wire                                ctrl_valid,
    input  wire pkt_addr_t                     ctrl_addr,
    input  wire payload_t                      ctrl_payload,
    input  wire [NUM_IN_PORTS-1:0]             pop,
    input  wire [NUM_OUT_PORTS-1:0]            sent,
    input  wire                                credit_taken,
    output logic [NUM_OUT_PORTS-1:0]           may_send,
    output route_t [NUM_OUT_PORTS-1:0]         out_route,
    output logic                               credit_req,
    output bft_packet_t                        credit_pkt,
    output logic                               kernel_rst_n
);

    localparam int FS_BITS     = $clog2(FREESPACE_UPDATE_SIZE);
    localparam int IN_IDX_BITS = $clog2(NUM_IN_PORTS);

    typedef enum logic {WAIT_START, RUN} run_state_e;

    run_state_e             state_q;
    route_t                 up_route_q [NUM_IN_PORTS];  // table entries 4..7
    credit_t                credit_q [NUM_OUT_PORTS];
    credit_t                credit_add [NUM_OUT_PORTS];
    logic [FS_BITS-1:0]     fs_cnt_q [NUM_IN_PORTS];
    logic [NUM_IN_PORTS-1:0] pend_q;
    logic [NUM_IN_PORTS-1:0] pend_set;
    logic [NUM_IN_PORTS-1:0] pend_clr;
    logic [IN_IDX_BITS-1:0] pend_sel;
    logic [2:0]             tbl_idx;
    logic                   cfg_wr;
    logic                   credit_ret;

    assign cfg_wr       = ctrl_valid & ctrl_addr[NUM_ADDR_BITS-1];
    assign credit_ret   = ctrl_valid & ~ctrl_addr[NUM_ADDR_BITS-1];
    assign tbl_idx      = ctrl_addr[2:0];
    assign kernel_rst_n = (state_q == RUN);
    assign credit_req   = |pend_q;

    // kernel stays in reset until ap_start shows up once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= WAIT_START;
        end else if (state_q == WAIT_START && ap_start) begin
            state_q <= RUN;
        end
    end

    // entries 0..2 route outputs and 4..7 name the upstream of each input
    always_ff @(posedge clk) begin
        if (cfg_wr && !tbl_idx[2] && int'(tbl_idx[1:0]) < NUM_OUT_PORTS) begin
            out_route[tbl_idx[1:0]] <= route_t'(ctrl_payload[$bits(route_t)-1:0]);
        end
        if (cfg_wr && tbl_idx[2]) begin
            up_route_q[tbl_idx[1:0]] <= route_t'(ctrl_payload[$bits(route_t)-1:0]);
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_OUT_PORTS; i++) begin
            credit_add[i] = '0;
            if (credit_ret && int'(ctrl_addr[NUM_ADDR_BITS-2:0]) == i) begin
                credit_add[i] = ctrl_payload[CREDIT_BITS-1:0];
            end
            may_send[i] = (credit_q[i] != '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                credit_q[i] <= credit_t'(CREDIT_INIT);
            end
        end else begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                credit_q[i] <= credit_q[i] + credit_add[i] - credit_t'(sent[i]);
            end
        end
    end

    // lowest pending input wins
    always_comb begin
        pend_sel = '0;
        for (int i = NUM_IN_PORTS - 1; i >= 0; i--) begin
            if (pend_q[i]) begin
                pend_sel = IN_IDX_BITS'(i);
            end
        end
        pend_clr = '0;
        if (credit_taken) begin
            pend_clr[pend_sel] = 1'b1;
        end
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            pend_set[i] = pop[i] && (fs_cnt_q[i] == FS_BITS'(FREESPACE_UPDATE_SIZE - 1));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= '0;
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                fs_cnt_q[i] <= '0;
            end
        end else begin
            pend_q <= (pend_q & ~pend_clr) | pend_set;
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                fs_cnt_q[i] <= fs_cnt_q[i] + FS_BITS'(pop[i]);  // wraps at the update size
            end
        end
    end

    always_comb begin
        credit_pkt.valid   = credit_req;
        credit_pkt.leaf    = up_route_q[pend_sel].leaf;
        credit_pkt.port    = port_id_t'(CTRL_PORT);
        credit_pkt.addr    = pkt_addr_t'(up_route_q[pend_sel].port);  // upstream output index
        credit_pkt.payload = payload_t'(FREESPACE_UPDATE_SIZE);
    end

endmodule

`default_nettype wire

//--- verilog/leaf_tx_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_tx_arbiter
    import leaf_pkg::*;
(
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              resend,
    input  wire [NUM_OUT_PORTS-1:0]          out_vld,
    input  wire payload_t [NUM_OUT_PORTS-1:0] out_data,
    input  wire [NUM_OUT_PORTS-1:0]          may_send,
    input  wire route_t [NUM_OUT_PORTS-1:0]  out_route,
    input  wire                              credit_req,
    input  wire bft_packet_t                 credit_pkt,
    output logic [NUM_OUT_PORTS-1:0]         out_ack,
    output logic [NUM_OUT_PORTS-1:0]         sent,
    output logic                             credit_taken,
    output bft_packet_t                      dout
);

    localparam int OUT_IDX_BITS = $clog2(NUM_OUT_PORTS);

    logic [NUM_OUT_PORTS-1:0] req;
    logic [OUT_IDX_BITS-1:0]  last_q;
    logic [OUT_IDX_BITS-1:0]  pick;
    logic                     pick_vld;
    logic                     do_credit;
    logic                     do_data;
    bft_packet_t              next_pkt;
    bft_packet_t              dout_q;

    assign req       = out_vld & may_send;
    assign do_credit = credit_req & ~resend;  // credit packets go before data
    assign do_data   = pick_vld & ~credit_req & ~resend;

    // round robin search starting just after the last served output
    always_comb begin
        int idx;
        pick     = last_q;
        pick_vld = 1'b0;
        for (int k = 1; k <= NUM_OUT_PORTS; k++) begin
            idx = (int'(last_q) + k) % NUM_OUT_PORTS;
            if (!pick_vld && req[idx]) begin
                pick     = OUT_IDX_BITS'(idx);
                pick_vld = 1'b1;
            end
        end
    end

    always_comb begin
        out_ack = '0;
        if (do_data) begin
            out_ack[pick] = 1'b1;
        end
        sent         = out_ack;
        credit_taken = do_credit;

        next_pkt = '0;
        if (do_credit) begin
            next_pkt = credit_pkt;
        end else if (do_data) begin
            next_pkt.valid   = 1'b1;
            next_pkt.leaf    = out_route[pick].leaf;
            next_pkt.port    = out_route[pick].port;
            next_pkt.addr    = '0;
            next_pkt.payload = out_data[pick];
        end
    end

    // a packet caught by resend is held and shows once resend drops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_q <= '0;
            last_q <= OUT_IDX_BITS'(NUM_OUT_PORTS - 1);
        end else if (!resend) begin
            dout_q <= next_pkt;
            if (do_data) begin
                last_q <= pick;
            end
        end
    end

    assign dout = resend ? '0 : dout_q;

endmodule

`default_nettype wire

//--- verilog/stream_kernel.sv
`timescale 1ns/1ps
`default_nettype none

module stream_kernel
    import leaf_pkg::*;
(
    input  wire                               clk,
    input  wire                               kernel_rst_n,
    input  wire [NUM_IN_PORTS-1:0]            in_vld,
    input  wire payload_t [NUM_IN_PORTS-1:0]  in_data,
    input  wire [NUM_OUT_PORTS-1:0]           out_ack,
    output logic [NUM_IN_PORTS-1:0]           in_ack,
    output logic [NUM_OUT_PORTS-1:0]          out_vld,
    output payload_t [NUM_OUT_PORTS-1:0]      out_data
);

    logic                     run_q;  // first cycle out of reset takes nothing
    logic [NUM_OUT_PORTS-1:0] load_ok;
    logic [NUM_OUT_PORTS-1:0] take;
    payload_t                 acc_q;
    payload_t                 acc_next;

    assign load_ok  = ~out_vld | out_ack;
    assign take[0]  = run_q & in_vld[0] & in_vld[1] & load_ok[0];  // pair from 1 and 2
    assign take[1]  = run_q & in_vld[2] & load_ok[1];
    assign take[2]  = run_q & in_vld[3] & load_ok[2];
    assign in_ack   = {take[2], take[1], take[0], take[0]};
    assign acc_next = acc_q + in_data[3];

    always_ff @(posedge clk or negedge kernel_rst_n) begin
        if (!kernel_rst_n) begin
            run_q   <= 1'b0;
            out_vld <= '0;
            acc_q   <= '0;
        end else begin
            run_q   <= 1'b1;
            out_vld <= (out_vld & ~out_ack) | take;
            if (take[2]) begin
                acc_q <= acc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take[0]) begin
            out_data[0] <= in_data[0] + in_data[1];
        end
        if (take[1]) begin
            out_data[1] <= (in_data[2] << 1) + in_data[2];  // times three
        end
        if (take[2]) begin
            out_data[2] <= acc_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/leaf_i4o3.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_i4o3
    import leaf_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire bft_packet_t din_leaf_bft2interface,
    input  wire              resend,
    input  wire              ap_start,
    output bft_packet_t      dout_leaf_interface2bft
);

    logic [NUM_IN_PORTS-1:0]      wr_en;
    payload_t                     wr_data;
    logic                         ctrl_valid;
    pkt_addr_t                    ctrl_addr;
    payload_t                     ctrl_payload;
    logic [NUM_IN_PORTS-1:0]      in_vld;
    logic [NUM_IN_PORTS-1:0]      in_ack;
    logic [NUM_IN_PORTS-1:0]      pop;
    payload_t [NUM_IN_PORTS-1:0]  in_data;
    logic [NUM_OUT_PORTS-1:0]     out_vld;
    logic [NUM_OUT_PORTS-1:0]     out_ack;
    payload_t [NUM_OUT_PORTS-1:0] out_data;
    logic [NUM_OUT_PORTS-1:0]     may_send;
    logic [NUM_OUT_PORTS-1:0]     sent;
    route_t [NUM_OUT_PORTS-1:0]   out_route;
    logic                         credit_req;
    logic                         credit_taken;
    bft_packet_t                  credit_pkt;
    logic                         kernel_rst_n;

    leaf_rx_decode leaf_rx_decode_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .din          (din_leaf_bft2interface),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .ctrl_valid   (ctrl_valid),
        .ctrl_addr    (ctrl_addr),
        .ctrl_payload (ctrl_payload)
    );

    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : gen_port
        port_fifo port_fifo_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (wr_en[i]),
            .wr_data (wr_data),
            .ack     (in_ack[i]),
            .vld     (in_vld[i]),
            .rd_data (in_data[i]),
            .pop     (pop[i])
        );
    end

    leaf_ctrl leaf_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .ap_start     (ap_start),
        .ctrl_valid   (ctrl_valid),
        .ctrl_addr    (ctrl_addr),
        .ctrl_payload (ctrl_payload),
        .pop          (pop),
        .sent         (sent),
        .credit_taken (credit_taken),
        .may_send     (may_send),
        .out_route    (out_route),
        .credit_req   (credit_req),
        .credit_pkt   (credit_pkt),
        .kernel_rst_n (kernel_rst_n)
    );

    leaf_tx_arbiter leaf_tx_arbiter_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .resend       (resend),
        .out_vld      (out_vld),
        .out_data     (out_data),
        .may_send     (may_send),
        .out_route    (out_route),
        .credit_req   (credit_req),
        .credit_pkt   (credit_pkt),
        .out_ack      (out_ack),
        .sent         (sent),
        .credit_taken (credit_taken),
        .dout         (dout_leaf_interface2bft)
    );

    stream_kernel stream_kernel_inst (
        .clk          (clk),
        .kernel_rst_n (kernel_rst_n),
        .in_vld       (in_vld),
        .in_data      (in_data),
        .out_ack      (out_ack),
        .in_ack       (in_ack),
        .out_vld      (out_vld),
        .out_data     (out_data)
    );

endmodule

`default_nettype wire

//--- sim/leaf_i4o3_assert.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_i4o3_assert
    import leaf_pkg::*;
(
    input wire                     clk,
    input wire                     rst_n,
    input wire                     resend,
    input wire [NUM_IN_PORTS-1:0]  wr_en,
    input wire [NUM_IN_PORTS-1:0]  pop,
    input wire                     ctrl_valid,
    input wire pkt_addr_t          ctrl_addr,
    input wire payload_t           ctrl_payload,
    input wire [NUM_OUT_PORTS-1:0] sent,
    input wire bft_packet_t        dout
);

    int fill [NUM_IN_PORTS];      // words held in each input queue
    int credits [NUM_OUT_PORTS];  // credits left per output
    int refill [NUM_OUT_PORTS];

    always_comb begin
        for (int i = 0; i < NUM_OUT_PORTS; i++) begin
            refill[i] = 0;
            if (ctrl_valid && !ctrl_addr[NUM_ADDR_BITS-1]
                    && int'(ctrl_addr[NUM_ADDR_BITS-2:0]) == i) begin
                refill[i] = int'(ctrl_payload);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                fill[i] <= 0;
            end
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                credits[i] <= CREDIT_INIT;
            end
        end else begin
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                fill[i] <= fill[i] + int'(wr_en[i]) - int'(pop[i]);
            end
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                credits[i] <= credits[i] + refill[i] - int'(sent[i]);
            end
        end
    end

    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : gen_queue
        assert property (@(posedge clk) disable iff (!rst_n) wr_en[i] |-> fill[i] < FIFO_DEPTH)
            else $error("input queue %0d written while full", i);
    end

    for (genvar i = 0; i < NUM_OUT_PORTS; i++) begin : gen_credit
        assert property (@(posedge clk) disable iff (!rst_n) sent[i] |-> credits[i] > 0)
            else $error("output %0d sent with no credit left", i);
    end

    assert property (@(posedge clk) disable iff (!rst_n) resend |-> dout == '0)
        else $error("network output not blank during resend");

endmodule

bind leaf_i4o3 leaf_i4o3_assert leaf_i4o3_assert_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .resend       (resend),
    .wr_en        (wr_en),
    .pop          (pop),
    .ctrl_valid   (ctrl_valid),
    .ctrl_addr    (ctrl_addr),
    .ctrl_payload (ctrl_payload),
    .sent         (sent),
    .dout         (dout_leaf_interface2bft)
);

`default_nettype wire

//--- sim/tb_leaf_i4o3.sv
`timescale 1ns/1ps
`default_nettype none

module tb_leaf_i4o3
    import leaf_pkg::*;
();

    localparam int DRAIN_TIMEOUT = 400;  // cycles to wait for the expected packets of a test
    localparam int QUIET_CYCLES  = 30;
    localparam int NUM_KEYS      = 1 << (NUM_LEAF_BITS + NUM_PORT_BITS);

    logic        clk;
    logic        rst_n;
    logic        resend;
    logic        ap_start;
    bft_packet_t din;
    bft_packet_t dout;

    byte         rec_kind [$];
    int          rec_test [$];
    bft_packet_t rec_pkt [$];
    bft_packet_t exp_q [NUM_KEYS][$];  // one queue per destination leaf and port

    int exp_count = 0;
    int got_count = 0;
    int checks    = 0;
    int errors    = 0;
    int last_test = 0;
    bit aborted   = 1'b0;
    bit verdict_done = 1'b0;

    leaf_i4o3 leaf_i4o3_inst (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din),
        .resend                  (resend),
        .ap_start                (ap_start),
        .dout_leaf_interface2bft (dout)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic load_records();
        int          fd;
        int          test;
        int          leaf;
        int          port;
        int          addr;
        logic [31:0] payload;
        byte         kind;
        string       line;
        bft_packet_t pkt;
        fd = $fopen("sim/leaf_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file sim/leaf_input.txt");
            aborted = 1'b1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                if ($sscanf(line, "%c %d %h %h %h %h", kind, test, leaf, port, addr,
                            payload) == 6) begin
                    pkt.valid   = 1'b1;
                    pkt.leaf    = leaf_id_t'(leaf);
                    pkt.port    = port_id_t'(port);
                    pkt.addr    = pkt_addr_t'(addr);
                    pkt.payload = payload;
                    rec_kind.push_back(kind);
                    rec_test.push_back(test);
                    rec_pkt.push_back(pkt);
                    if (test > last_test) begin
                        last_test = test;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_packet(input bft_packet_t pkt);
        int gap;
        gap = int'($urandom % 4);  // idle cycles after the packet
        @(negedge clk);
        din = pkt;
        @(negedge clk);
        din = '0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic hold_resend(input int cycles);
        @(negedge clk);
        resend = 1'b1;
        repeat (cycles) @(negedge clk);
        resend = 1'b0;
    endtask

    task automatic push_expected(input bft_packet_t pkt);
        int key;
        key = int'({pkt.leaf, pkt.port});
        exp_q[key].push_back(pkt);
        exp_count++;
    endtask

    task automatic apply_record(input byte kind, input bft_packet_t pkt);
        case (kind)
            "P": send_packet(pkt);
            "R": hold_resend(int'(pkt.payload));
            "A": begin
                @(negedge clk);
                ap_start = pkt.payload[0];
            end
            default: ;
        endcase
    endtask

    task automatic run_test(input int t);
        int err_before;
        int waited;
        err_before = errors;
        // queue the expected side first so no packet can beat its entry
        foreach (rec_kind[i]) begin
            if (rec_test[i] == t && rec_kind[i] == "E") begin
                push_expected(rec_pkt[i]);
            end
        end
        foreach (rec_kind[i]) begin
            if (rec_test[i] == t && rec_kind[i] != "E") begin
                apply_record(rec_kind[i], rec_pkt[i]);
            end
        end
        waited = 0;
        while (exp_count != got_count && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_count != got_count) begin
            $display("test %0d timed out, %0d expected packets never arrived", t,
                     exp_count - got_count);
            aborted = 1'b1;
        end else begin
            repeat (QUIET_CYCLES) @(negedge clk);  // stray packets show up here
            $display("test %0d done, %0d errors", t, errors - err_before);
        end
    endtask

    // registered output is sampled on the rising edge
    always @(posedge clk) begin
        int key;
        if (rst_n) begin
            if (resend) begin
                check_value("output while resend is high", 64'(dout), 64'd0);
            end
            if (dout.valid === 1'b1) begin
                key = int'({dout.leaf, dout.port});
                if (exp_q[key].size() == 0) begin
                    errors++;
                    $display("unexpected packet at %0t to leaf %0d port %0d, payload %h",
                             $time, dout.leaf, dout.port, dout.payload);
                end else begin
                    check_value($sformatf("packet to leaf %0d port %0d", dout.leaf, dout.port),
                                64'(dout), 64'(exp_q[key].pop_front()));
                    got_count++;
                end
            end
        end
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        resend   = 1'b0;
        ap_start = 1'b0;
        din      = '0;
        void'($urandom(9255));
        load_records();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        for (int t = 1; t <= last_test && !aborted; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d checks, %0d errors", last_test, checks, errors);
        verdict_done = 1'b1;
        if (errors == 0 && !aborted) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // the run ended before the verdict was printed
    final begin
        if (!verdict_done) begin
            $display("Result: FAILED");
        end
    end

endmodule

`default_nettype wire

//--- sim/leaf_input.txt
# kind test leaf port addr payload, test in decimal, the rest in hex
# P packet to drive, A ap_start level in payload, R resend cycles in payload, E expected packet
P 1 01 0 40 00000021
P 1 01 0 41 00000032
P 1 01 0 42 00000043
P 1 01 0 44 00000080
P 1 01 0 45 00000091
P 1 01 0 46 000000a2
P 1 01 0 47 000000b0
P 1 01 1 00 00000001
P 1 01 1 00 00000002
P 1 01 2 00 0000000a
P 1 01 2 00 00000014
P 1 01 3 00 00000005
A 2 00 0 00 00000001
P 2 01 1 00 00000003
P 2 01 2 00 0000001e
P 2 01 3 00 00000006
P 2 01 3 00 00000007
P 2 01 4 00 00000001
P 2 01 4 00 00000002
P 2 01 4 00 00000003
P 2 01 0 01 00000003
E 2 02 1 00 0000000b
E 2 02 1 00 00000016
E 2 02 1 00 00000021
E 2 03 2 00 0000000f
E 2 03 2 00 00000012
E 2 03 2 00 00000015
E 2 04 3 00 00000001
E 2 04 3 00 00000003
E 2 04 3 00 00000006
P 3 01 3 00 00000001
P 3 01 3 00 00000002
P 3 01 3 00 00000003
P 3 01 3 00 00000004
P 3 01 3 00 00000005
P 3 01 3 00 00000006
P 3 01 3 00 00000007
P 3 01 3 00 00000008
P 3 01 3 00 00000009
E 3 03 2 00 00000003
E 3 03 2 00 00000006
E 3 03 2 00 00000009
E 3 03 2 00 0000000c
E 3 03 2 00 0000000f
E 3 03 2 00 00000012
E 3 03 2 00 00000015
E 3 03 2 00 00000018
E 3 0a 0 02 00000004
E 3 0a 0 02 00000004
E 3 0a 0 02 00000004
P 4 01 0 01 00000001
E 4 03 2 00 0000001b
P 5 01 1 00 00000004
P 5 01 2 00 00000028
P 5 01 4 00 00000004
E 5 02 1 00 0000002c
E 5 04 3 00 0000000a
E 5 08 0 00 00000004
E 5 09 0 01 00000004
E 5 0b 0 00 00000004
P 6 01 1 00 00000005
P 6 01 2 00 00000032
R 6 00 0 00 00000014
P 6 01 4 00 00000005
P 6 01 4 00 00000006
R 6 00 0 00 0000000c
E 6 02 1 00 00000037
E 6 04 3 00 0000000f
E 6 04 3 00 00000015

//--- leaf_i4o3.f
verilog/leaf_pkg.sv
verilog/leaf_rx_decode.sv
verilog/port_fifo.sv
verilog/leaf_ctrl.sv
verilog/leaf_tx_arbiter.sv
verilog/stream_kernel.sv
verilog/leaf_i4o3.sv
sim/leaf_i4o3_assert.sv
sim/tb_leaf_i4o3.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_leaf_i4o3
FILELIST := leaf_i4o3.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
